// File: build.f
design/dcache_pkg.sv
design/store_if.sv
design/lookup_if.sv
design/dcache_store.sv
design/dcache_lookup.sv
design/dcache_ctrl.sv
design/dcache_top.sv
bench/tb_dcache.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_dcache
FLIST = build.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || (echo "simulation failed"; exit 1)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ) $(LOG)

// File: bench/tb_dcache.sv
// testbench for the two-way data cache with golden word memory,
// behavioral next-level responder, handshake assertions and watchdog
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int INDEX_BITS   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int N_ACCESS     = 76;                 // accesses over all tests
    localparam logic [WORD_W-1:0] PAT = 32'h5A3C_96E1;

    logic              clk;
    logic              rst_n;
    logic              cpu_req;
    cpu_op_e           cpu_op;
    logic [ADDR_W-1:0] cpu_addr;
    logic [WORD_W-1:0] cpu_wdata;
    logic              cpu_ack;
    logic [WORD_W-1:0] cpu_rdata;
    logic              l2_req;
    logic              l2_we;
    logic [ADDR_W-1:0] l2_addr;
    line_t             l2_wline;
    logic              l2_ack;
    line_t             l2_rline;

    logic [WORD_W-1:0] golden [logic [ADDR_W-1:0]];   // word address to word
    line_t             l2_mem [logic [ADDR_W-1:0]];   // lines written back
    logic              xfer_we [$];                   // transfers of the current access
    logic [ADDR_W-1:0] wb_addr;
    line_t             wb_line;
    logic [ADDR_W-1:0] pool [12];
    logic [WORD_W-1:0] rd;
    int                lat;
    int                errors;
    int                tests_ok;
    int                tests_bad;

    dcache_top #(.INDEX_BITS(INDEX_BITS)) u_dcache_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .cpu_op    (cpu_op),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .l2_req    (l2_req),
        .l2_we     (l2_we),
        .l2_addr   (l2_addr),
        .l2_wline  (l2_wline),
        .l2_ack    (l2_ack),
        .l2_rline  (l2_rline)
    );

    always #20 clk = ~clk;

    function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int idx, input int word);
        return ADDR_W'((tag << (LINE_OFF_W + INDEX_BITS)) | (idx << LINE_OFF_W) | (word << 2));
    endfunction

    function automatic logic [WORD_W-1:0] expected_word(input logic [ADDR_W-1:0] a);
        if (golden.exists(a)) begin
            return golden[a];
        end
        return a ^ PAT;                               // untouched memory
    endfunction

    function automatic line_t expected_line(input logic [ADDR_W-1:0] base);
        line_t l;
        for (int w = 0; w < LINE_WORDS; w++) begin
            l[w] = expected_word(base + ADDR_W'(4 * w));
        end
        return l;
    endfunction

    function automatic line_t stored_line(input logic [ADDR_W-1:0] base);
        line_t l;
        if (l2_mem.exists(base)) begin
            return l2_mem[base];
        end
        for (int w = 0; w < LINE_WORDS; w++) begin
            l[w] = (base + ADDR_W'(4 * w)) ^ PAT;     // preset pattern
        end
        return l;
    endfunction

    task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
        assert (got == exp) else begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        assert (got == exp) else begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%0t ns: %s", $time, what);
            errors++;
        end
    endtask

    // one full four-phase CPU access, cycles counted from the edge that samples cpu_req
    task automatic access(input cpu_op_e op, input logic [ADDR_W-1:0] addr,
                          input logic [WORD_W-1:0] wdata,
                          output logic [WORD_W-1:0] rdata, output int cycles);
        xfer_we.delete();
        @(posedge clk);
        #2;
        cpu_req   = 1'b1;
        cpu_op    = op;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        cycles    = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!cpu_ack);
        rdata = cpu_rdata;
        if (op == OP_WRITE) begin
            golden[addr] = wdata;
        end
        @(posedge clk);
        #2;
        cpu_req = 1'b0;
        while (cpu_ack) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic read_expect(input logic [ADDR_W-1:0] addr);
        logic [WORD_W-1:0] exp;
        exp = expected_word(addr);
        access(OP_READ, addr, '0, rd, lat);
        check_word("cpu_rdata", rd, exp);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: failed", name);
        end
    endtask

    // next-level memory, answers each request after 1 to 4 cycles
    initial begin
        logic [ADDR_W-1:0] base;
        logic              we;
        int                dly;
        l2_ack   = 1'b0;
        l2_rline = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && l2_req) begin
                base = l2_addr;
                we   = l2_we;
                xfer_we.push_back(we);
                if (we) begin
                    wb_addr      = base;
                    wb_line      = l2_wline;
                    l2_mem[base] = l2_wline;
                end
                dly = $urandom_range(1, 4);
                repeat (dly) @(posedge clk);
                #2;
                l2_rline = we ? '0 : stored_line(base);
                l2_ack   = 1'b1;
                do begin
                    @(posedge clk);
                    #1;
                end while (l2_req);
                dly = $urandom_range(0, 2);           // ack may linger after req drops
                repeat (dly) begin
                    @(posedge clk);
                    #1;
                end
                #1;
                l2_ack = 1'b0;                        // 2 ns after the edge
            end
        end
    end

    a_cpu_ack_drop: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(cpu_req) |=> !cpu_ack)
        else begin
            $display("%0t ns: cpu_ack still high a cycle after cpu_req fell", $time);
            errors++;
        end

    a_l2_stable: assert property (@(posedge clk) disable iff (!rst_n)
        l2_req && !l2_ack |=> l2_req && $stable(l2_addr) && $stable(l2_we)
                              && $stable(l2_wline))
        else begin
            $display("%0t ns: next-level request changed before l2_ack", $time);
            errors++;
        end

    a_l2_new_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(l2_req) |-> !l2_ack)
        else begin
            $display("%0t ns: new l2_req raised while l2_ack was still high", $time);
            errors++;
        end

    initial begin
        repeat (RESET_CYCLES + 200 * N_ACCESS) @(posedge clk);
        $display("watchdog expired, the cache stopped answering");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int                e0;
        logic [ADDR_W-1:0] a;
        logic [WORD_W-1:0] d;
        line_t             exp_line;
        void'($urandom(19));
        clk       = 1'b0;
        rst_n     = 1'b0;
        cpu_req   = 1'b0;
        cpu_op    = OP_READ;
        cpu_addr  = '0;
        cpu_wdata = '0;
        errors    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;

        e0 = errors;
        check_true(!cpu_ack && !l2_req, "cpu_ack or l2_req high after reset");
        read_expect(make_addr(1, 3, 2));
        check_count("next-level transfers", xfer_we.size(), 1);
        if (xfer_we.size() == 1) begin
            check_true(!xfer_we[0], "first read issued a write request");
        end
        finish_test("reset state and first read", e0);

        e0 = errors;
        read_expect(make_addr(1, 3, 0));
        check_count("read hit latency", lat, 3);
        check_count("next-level transfers", xfer_we.size(), 0);
        finish_test("read hit", e0);

        e0 = errors;
        access(OP_WRITE, make_addr(1, 3, 1), 32'hCAFE_0031, rd, lat);
        check_count("write hit latency", lat, 4);
        check_count("next-level transfers", xfer_we.size(), 0);
        for (int w = 0; w < LINE_WORDS; w++) begin
            read_expect(make_addr(1, 3, w));
            check_count("next-level transfers", xfer_we.size(), 0);
        end
        finish_test("write hit and read-back", e0);

        e0 = errors;
        access(OP_WRITE, make_addr(2, 5, 0), 32'hD1A7_0250, rd, lat);
        read_expect(make_addr(3, 5, 0));
        exp_line = expected_line(make_addr(2, 5, 0));
        read_expect(make_addr(4, 5, 0));
        check_count("next-level transfers", xfer_we.size(), 2);
        if (xfer_we.size() == 2) begin
            check_true(xfer_we[0] && !xfer_we[1], "writeback did not precede the refill");
        end
        check_word("l2_addr", wb_addr, make_addr(2, 5, 0));
        check_line("l2_wline", wb_line, exp_line);
        read_expect(make_addr(2, 5, 0));              // refetch of the written line
        check_count("next-level transfers", xfer_we.size(), 1);
        finish_test("dirty eviction", e0);

        e0 = errors;
        read_expect(make_addr(5, 9, 0));
        read_expect(make_addr(6, 9, 0));
        read_expect(make_addr(7, 9, 0));
        check_count("next-level transfers", xfer_we.size(), 1);
        if (xfer_we.size() == 1) begin
            check_true(!xfer_we[0], "clean eviction issued a write request");
        end
        read_expect(make_addr(7, 9, 1));
        check_count("next-level transfers", xfer_we.size(), 0);
        read_expect(make_addr(6, 9, 2));              // survivor of the LRU choice
        check_count("next-level transfers", xfer_we.size(), 0);
        finish_test("clean eviction and LRU", e0);

        e0 = errors;
        for (int i = 0; i < 12; i++) begin
            pool[i] = make_addr(8 + i % 3, 12 + (i / 3) % 2, i % 4);
        end
        for (int n = 0; n < 60; n++) begin
            a = pool[$urandom_range(0, 11)];
            if ($urandom_range(0, 1) == 1) begin
                d = $urandom();
                access(OP_WRITE, a, d, rd, lat);
            end else begin
                read_expect(a);
            end
        end
        finish_test("random accesses and handshakes", e0);

        $display("tests passed: %0d, tests failed: %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: design/dcache_top.sv
// two-way write-back L1 data cache top level
// plain CPU and next-level ports around ctrl, lookup and store
`timescale 1ns/1ps

module dcache_top #(
    parameter int INDEX_BITS = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cpu_req,
    input  dcache_pkg::cpu_op_e           cpu_op,
    input  logic [dcache_pkg::ADDR_W-1:0] cpu_addr,
    input  logic [dcache_pkg::WORD_W-1:0] cpu_wdata,
    output logic                          cpu_ack,
    output logic [dcache_pkg::WORD_W-1:0] cpu_rdata,
    output logic                          l2_req,
    output logic                          l2_we,
    output logic [dcache_pkg::ADDR_W-1:0] l2_addr,
    output dcache_pkg::line_t             l2_wline,
    input  logic                          l2_ack,
    input  dcache_pkg::line_t             l2_rline
);
    import dcache_pkg::*;

    logic [ADDR_W-1:0] lat_addr;    // access under service
    logic [WORD_W-1:0] lat_wdata;

    store_if  #(.INDEX_BITS(INDEX_BITS)) u_store_if (.clk(clk));
    lookup_if #(.INDEX_BITS(INDEX_BITS)) u_lookup_if ();

    dcache_ctrl #(.INDEX_BITS(INDEX_BITS)) u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .cpu_op    (cpu_op),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .l2_req    (l2_req),
        .l2_we     (l2_we),
        .l2_addr   (l2_addr),
        .l2_wline  (l2_wline),
        .l2_ack    (l2_ack),
        .l2_rline  (l2_rline),
        .lat_addr  (lat_addr),
        .lat_wdata (lat_wdata),
        .mem       (u_store_if.ctrl),
        .res       (u_lookup_if.ctrl)
    );

    dcache_lookup #(.INDEX_BITS(INDEX_BITS)) u_lookup (
        .addr  (lat_addr),
        .wdata (lat_wdata),
        .mem   (u_store_if.lookup),
        .res   (u_lookup_if.lookup)
    );

    dcache_store #(.INDEX_BITS(INDEX_BITS)) u_store (
        .clk   (clk),
        .rst_n (rst_n),
        .mem   (u_store_if.store)
    );

endmodule

// File: design/dcache_ctrl.sv
// cache controller FSM for the CPU and next-level handshakes,
// writeback, refill and write-hit update
`timescale 1ns/1ps

module dcache_ctrl #(
    parameter int INDEX_BITS = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cpu_req,
    input  dcache_pkg::cpu_op_e           cpu_op,
    input  logic [dcache_pkg::ADDR_W-1:0] cpu_addr,
    input  logic [dcache_pkg::WORD_W-1:0] cpu_wdata,
    output logic                          cpu_ack,
    output logic [dcache_pkg::WORD_W-1:0] cpu_rdata,
    output logic                          l2_req,
    output logic                          l2_we,
    output logic [dcache_pkg::ADDR_W-1:0] l2_addr,
    output dcache_pkg::line_t             l2_wline,
    input  logic                          l2_ack,
    input  dcache_pkg::line_t             l2_rline,
    output logic [dcache_pkg::ADDR_W-1:0] lat_addr,
    output logic [dcache_pkg::WORD_W-1:0] lat_wdata,
    store_if.ctrl                         mem,
    lookup_if.ctrl                        res
);
    import dcache_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_BITS - LINE_OFF_W;

    ctrl_state_e           state;
    cpu_op_e               lat_op;
    logic [TAG_W-1:0]      lat_tag;
    logic [INDEX_BITS-1:0] lat_index;

    assign lat_tag   = lat_addr[ADDR_W-1 -: TAG_W];
    assign lat_index = lat_addr[LINE_OFF_W +: INDEX_BITS];

    // store commands
    always_comb begin
        mem.rd_index = (state == ST_IDLE) ? cpu_addr[LINE_OFF_W +: INDEX_BITS] : lat_index;
        mem.we       = 1'b0;
        mem.wr_way   = res.hit_way;
        mem.wr_tag   = lat_tag;
        mem.wr_dirty = 1'b1;
        mem.wr_line  = res.merged_line;
        mem.lru_upd  = 1'b0;
        mem.lru_way  = res.hit_way;
        case (state)
            ST_LOOKUP:    mem.lru_upd = res.hit;
            ST_WRITE_HIT: mem.we = 1'b1;
            ST_FILL_WAIT: begin
                mem.we       = l2_ack;          // refill lands clean
                mem.wr_way   = res.victim_way;
                mem.wr_dirty = 1'b0;
                mem.wr_line  = l2_rline;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            cpu_ack <= 1'b0;
            l2_req  <= 1'b0;
            l2_we   <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cpu_req) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (res.hit) begin
                        state <= (lat_op == OP_WRITE) ? ST_WRITE_HIT : ST_RESPOND;
                    end else if (res.victim_dirty) begin
                        state <= ST_WB_REQ;
                    end else begin
                        state <= ST_FILL_REQ;
                    end
                end
                ST_WRITE_HIT: state <= ST_RESPOND;
                ST_WB_REQ: begin
                    if (!l2_ack) begin           // previous transfer fully closed
                        l2_req <= 1'b1;
                        l2_we  <= 1'b1;
                        state  <= ST_WB_WAIT;
                    end
                end
                ST_WB_WAIT: begin
                    if (l2_ack) begin
                        l2_req <= 1'b0;
                        state  <= ST_FILL_REQ;
                    end
                end
                ST_FILL_REQ: begin
                    if (!l2_ack) begin
                        l2_req <= 1'b1;
                        l2_we  <= 1'b0;
                        state  <= ST_FILL_WAIT;
                    end
                end
                ST_FILL_WAIT: begin
                    if (l2_ack) begin
                        l2_req <= 1'b0;
                        state  <= ST_LOOKUP;     // retry now hits
                    end
                end
                ST_RESPOND: begin
                    if (!cpu_ack) begin
                        cpu_ack <= 1'b1;
                    end else if (!cpu_req) begin
                        cpu_ack <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // access latch and transfer payload
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cpu_req) begin
            lat_addr  <= cpu_addr;
            lat_wdata <= cpu_wdata;
            lat_op    <= cpu_op;
        end
        if (state == ST_LOOKUP && res.hit && lat_op == OP_READ) begin
            cpu_rdata <= res.rd_word;
        end
        if (state == ST_WB_REQ && !l2_ack) begin
            l2_addr  <= {res.victim_addr, {LINE_OFF_W{1'b0}}};
            l2_wline <= mem.rd_line[res.victim_way];
        end
        if (state == ST_FILL_REQ && !l2_ack) begin
            l2_addr <= {lat_addr[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
        end
    end

    a_l2_hold: assert property (@(posedge clk) disable iff (!rst_n)
        l2_req && !l2_ack |=> l2_req && $stable(l2_addr));

    a_ack_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cpu_ack) |-> $past(cpu_req));

endmodule

// File: design/dcache_lookup.sv
// tag compare, hit way and victim selection
// read word extraction and store-word merge
`timescale 1ns/1ps

module dcache_lookup #(
    parameter int INDEX_BITS = 4
) (
    input  logic [dcache_pkg::ADDR_W-1:0] addr,
    input  logic [dcache_pkg::WORD_W-1:0] wdata,
    store_if.lookup                       mem,
    lookup_if.lookup                      res
);
    import dcache_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_BITS - LINE_OFF_W;

    logic [TAG_W-1:0]      tag;
    logic [INDEX_BITS-1:0] index;
    logic [WORD_SEL_W-1:0] word_sel;
    logic [WAYS-1:0]       way_hit;
    logic                  hit_way;
    logic                  vway;
    line_t                 hit_line;

    assign tag      = addr[ADDR_W-1 -: TAG_W];
    assign index    = addr[LINE_OFF_W +: INDEX_BITS];
    assign word_sel = addr[LINE_OFF_W-1 -: WORD_SEL_W];

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = mem.rd_valid[w] && (mem.rd_tag[w] == tag);
        end
    end

    assign hit_way  = way_hit[1] & ~way_hit[0];
    assign hit_line = mem.rd_line[hit_way];

    assign res.hit     = |way_hit;
    assign res.hit_way = hit_way;
    assign res.rd_word = hit_line[word_sel];

    always_comb begin
        res.merged_line           = hit_line;
        res.merged_line[word_sel] = wdata;    // store word replaces one slot
    end

    // empty way first, otherwise the least recently used one
    always_comb begin
        if (!mem.rd_valid[0]) begin
            vway = 1'b0;
        end else if (!mem.rd_valid[1]) begin
            vway = 1'b1;
        end else begin
            vway = mem.rd_lru;
        end
    end

    assign res.victim_way   = vway;
    assign res.victim_dirty = mem.rd_valid[vway] && mem.rd_dirty[vway];
    assign res.victim_addr  = {mem.rd_tag[vway], index};

    // a set never holds the same valid tag twice
    a_one_hit: assert property (@(posedge mem.clk) !(way_hit[0] && way_hit[1]));

endmodule

// File: design/dcache_store.sv
// two-way tag, valid, dirty and line arrays with one LRU bit per set
// registered read, single-way synchronous write with forwarding
`timescale 1ns/1ps

module dcache_store #(
    parameter int INDEX_BITS = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    store_if.store mem
);
    import dcache_pkg::*;

    localparam int SETS  = 2 ** INDEX_BITS;
    localparam int TAG_W = ADDR_W - INDEX_BITS - LINE_OFF_W;

    logic [TAG_W-1:0]           tag_arr  [WAYS][SETS];
    line_t                      line_arr [WAYS][SETS];
    logic [WAYS-1:0][SETS-1:0]  valid_arr;
    logic [WAYS-1:0][SETS-1:0]  dirty_arr;
    logic [SETS-1:0]            lru_arr;
    logic [INDEX_BITS-1:0]      idx_q;       // set currently on the read outputs
    logic                       same_set;

    assign same_set = (mem.rd_index == idx_q);

    // status bits and their read registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q        <= '0;
            valid_arr    <= '0;
            dirty_arr    <= '0;
            lru_arr      <= '0;
            mem.rd_valid <= '0;
            mem.rd_dirty <= '0;
            mem.rd_lru   <= 1'b0;
        end else begin
            idx_q <= mem.rd_index;
            for (int w = 0; w < WAYS; w++) begin
                mem.rd_valid[w] <= valid_arr[w][mem.rd_index];
                mem.rd_dirty[w] <= dirty_arr[w][mem.rd_index];
            end
            mem.rd_lru <= lru_arr[mem.rd_index];
            if (mem.we) begin
                valid_arr[mem.wr_way][idx_q] <= 1'b1;
                dirty_arr[mem.wr_way][idx_q] <= mem.wr_dirty;
                if (same_set) begin              // refill visible on next lookup
                    mem.rd_valid[mem.wr_way] <= 1'b1;
                    mem.rd_dirty[mem.wr_way] <= mem.wr_dirty;
                end
            end
            if (mem.lru_upd) begin
                lru_arr[idx_q] <= ~mem.lru_way;  // point at the other way
                if (same_set) begin
                    mem.rd_lru <= ~mem.lru_way;
                end
            end
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            mem.rd_tag[w]  <= tag_arr[w][mem.rd_index];
            mem.rd_line[w] <= line_arr[w][mem.rd_index];
        end
        if (mem.we) begin
            tag_arr[mem.wr_way][idx_q]  <= mem.wr_tag;
            line_arr[mem.wr_way][idx_q] <= mem.wr_line;
            if (same_set) begin
                mem.rd_tag[mem.wr_way]  <= mem.wr_tag;
                mem.rd_line[mem.wr_way] <= mem.wr_line;
            end
        end
    end

    // writes land in the set the controller has held since the read
    a_wr_set: assert property (@(posedge clk) disable iff (!rst_n)
        (mem.we || mem.lru_upd) |-> (int'(idx_q) < SETS) && (mem.rd_index == idx_q));

endmodule

// File: design/lookup_if.sv
// hit and victim decode results from the lookup to the controller
`timescale 1ns/1ps

interface lookup_if #(
    parameter int INDEX_BITS = 4
);
    import dcache_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_BITS - LINE_OFF_W;

    logic                        hit;
    logic                        hit_way;
    logic                        victim_way;
    logic                        victim_dirty;  // victim valid and dirty
    logic [TAG_W+INDEX_BITS-1:0] victim_addr;   // line address of the old line
    logic [WORD_W-1:0]           rd_word;
    line_t                       merged_line;   // hit line with store word inserted

    modport lookup (
        output hit, hit_way, victim_way, victim_dirty, victim_addr, rd_word, merged_line
    );

    modport ctrl (
        input  hit, hit_way, victim_way, victim_dirty, victim_addr, rd_word, merged_line
    );

endinterface

// File: design/store_if.sv
// array read results and array write commands between the store,
// the lookup and the controller
`timescale 1ns/1ps

interface store_if #(
    parameter int INDEX_BITS = 4
) (
    input logic clk
);
    import dcache_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_BITS - LINE_OFF_W;

    logic [INDEX_BITS-1:0]       rd_index;  // set to read, result next cycle
    logic                        we;
    logic                        wr_way;
    logic [TAG_W-1:0]            wr_tag;
    logic                        wr_dirty;
    line_t                       wr_line;
    logic                        lru_upd;
    logic                        lru_way;   // way just used

    logic [WAYS-1:0][TAG_W-1:0]  rd_tag;
    logic [WAYS-1:0]             rd_valid;
    logic [WAYS-1:0]             rd_dirty;
    line_t [WAYS-1:0]            rd_line;
    logic                        rd_lru;

    modport store (
        input  rd_index, we, wr_way, wr_tag, wr_dirty, wr_line, lru_upd, lru_way,
        output rd_tag, rd_valid, rd_dirty, rd_line, rd_lru
    );

    modport lookup (
        input  clk, rd_tag, rd_valid, rd_dirty, rd_line, rd_lru
    );

    modport ctrl (
        output rd_index, we, wr_way, wr_tag, wr_dirty, wr_line, lru_upd, lru_way,
        input  rd_line
    );

endinterface

// File: design/dcache_pkg.sv
// cache geometry constants, line type
// access opcode and controller state enums
package dcache_pkg;

    localparam int WORD_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int WAYS       = 2;
    localparam int LINE_WORDS = 4;
    localparam int WORD_SEL_W = $clog2(LINE_WORDS);   // word offset, addr[3:2]
    localparam int LINE_OFF_W = WORD_SEL_W + 2;       // byte offset within a line

    // word 0 sits in the low 32 bits
    typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cpu_op_e;

    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_LOOKUP    = 3'd1,
        ST_WRITE_HIT = 3'd2,
        ST_WB_REQ    = 3'd3,
        ST_WB_WAIT   = 3'd4,
        ST_FILL_REQ  = 3'd5,
        ST_FILL_WAIT = 3'd6,
        ST_RESPOND   = 3'd7
    } ctrl_state_e;

endpackage
